// File: flist.f
+incdir+tb
source/lcd_pkg.sv
source/lcd_apb_regs.sv
source/lcd_word_fifo.sv
source/lcd_ctrl.sv
source/lcd_top.sv
tb/lcd_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module lcd_tb -f flist.f \
	--Mdir obj_dir -o lcd_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/lcd_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "TEST RESULT: PASS" <<< "$sim_out"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: source/lcd_apb_regs.sv
`timescale 1ns/1ps

module lcd_apb_regs import lcd_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  apb_req_t    apb_req,
	output apb_rsp_t    apb_rsp,
	output lcd_cfg_t    cfg,
	output logic        init_start,
	output logic        push,
	output lcd_word_t   wdata,
	input  lcd_status_t status
);

	logic     access;
	logic     wr;
	logic     rd;
	logic     mapped;
	logic     err;
	lcd_reg_e addr;
	lcd_cfg_t cfg_q;

	assign access = apb_req.psel && apb_req.penable;  // second cycle of a transfer
	assign wr     = access && apb_req.pwrite;
	assign rd     = access && !apb_req.pwrite;
	assign addr   = lcd_reg_e'(apb_req.paddr);

	always_comb begin
		case (addr)
			REG_CFG, REG_CTRL, REG_TXDATA, REG_STATUS: mapped = 1'b1;
			default: mapped = 1'b0;
		endcase
	end

	// refused accesses
	always_comb begin
		err = 1'b0;
		if (access) begin
			if (!mapped)
				err = 1'b1;
			else if (wr && addr == REG_TXDATA && status.full)
				err = 1'b1;  // queue cannot take it
			else if (wr && addr == REG_STATUS)
				err = 1'b1;  // read-only
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cfg_q <= '0;
		end else if (wr && addr == REG_CFG) begin
			cfg_q <= lcd_cfg_t'(apb_req.pwdata[6:0]);
		end
	end

	assign cfg = cfg_q;

	// single-cycle strobes straight from the access phase
	assign init_start = wr && addr == REG_CTRL && apb_req.pwdata[0];
	assign push       = wr && addr == REG_TXDATA && !status.full;
	assign wdata      = lcd_word_t'(apb_req.pwdata[9:0]);

	always_comb begin
		apb_rsp.prdata  = '0;
		apb_rsp.pready  = 1'b1;  // no wait states
		apb_rsp.pslverr = err;
		if (rd) begin
			case (addr)
				REG_CFG:    apb_rsp.prdata = 32'(cfg_q);
				REG_STATUS: apb_rsp.prdata = 32'(status);
				default:    apb_rsp.prdata = '0;
			endcase
		end
	end

	// access phase must follow a setup phase
	a_apb_setup_first: assert property (
		@(posedge clk) disable iff (!arst_n)
		$rose(apb_req.penable) |-> apb_req.psel && $past(apb_req.psel && !apb_req.penable)
	) else $error("penable raised without a setup cycle");

endmodule

// File: source/lcd_ctrl.sv
`timescale 1ns/1ps

module lcd_ctrl import lcd_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  lcd_cfg_t  cfg,
	input  logic      init_start,
	input  lcd_word_t word,
	input  logic      empty,
	output logic      pop,
	output lcd_pins_t pins,
	output logic      init_done,
	output logic      busy
);

	lcd_state_e             state;
	lcd_init_step_e         step;
	logic [LCD_CNT_W-1:0]   cnt;
	logic [LCD_CNT_W-1:0]   step_last;
	logic [7:0]             init_cmd;
	lcd_word_t              word_q;
	logic                   start_ok;

	// settle time after each init command
	function automatic int settle_ticks(lcd_init_step_e s);
		case (s)
			STEP_FUNC_SET:  return T_SETTLE_FUNC;
			STEP_DISP_CTRL: return T_SETTLE_DISP;
			STEP_CLEAR:     return T_SETTLE_CLEAR;
			default:        return T_SETTLE_ENTRY;
		endcase
	endfunction

	// command byte per init step, built from the stored configuration
	always_comb begin
		case (step)
			STEP_FUNC_SET:  init_cmd = {4'b0011, cfg.lines, cfg.font, 2'b00};
			STEP_DISP_CTRL: init_cmd = {5'b00001, cfg.disp_on, cfg.cursor_on, cfg.blink};
			STEP_CLEAR:     init_cmd = 8'h01;
			default:        init_cmd = {6'b000001, cfg.inc_dec, cfg.shift};
		endcase
	end

	assign step_last = LCD_CNT_W'(T_CMD_E + settle_ticks(step) - 1);
	assign start_ok  = init_start && (state == ST_IDLE || state == ST_READY);
	assign pop       = state == ST_READY && !empty && init_done && !start_ok;
	assign busy      = !(state == ST_IDLE || state == ST_READY);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= ST_IDLE;
			step      <= STEP_FUNC_SET;
			cnt       <= '0;
			init_done <= 1'b0;
		end else begin
			case (state)
				ST_IDLE, ST_READY: begin
					cnt <= '0;
					if (start_ok) begin
						state     <= ST_POWER_UP;
						init_done <= 1'b0;
					end else if (pop) begin
						state <= ST_PULSE;
					end
				end
				ST_POWER_UP: begin
					if (cnt == LCD_CNT_W'(T_POWER_UP - 1)) begin
						cnt   <= '0;
						step  <= STEP_FUNC_SET;
						state <= ST_INIT;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				ST_INIT: begin
					if (cnt == step_last) begin
						cnt <= '0;
						case (step)
							STEP_FUNC_SET:  step <= STEP_DISP_CTRL;
							STEP_DISP_CTRL: step <= STEP_CLEAR;
							STEP_CLEAR:     step <= STEP_ENTRY_MODE;
							default: begin
								step      <= STEP_FUNC_SET;
								state     <= ST_READY;
								init_done <= 1'b1;  // panel configured
							end
						endcase
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				ST_PULSE: begin
					if (cnt == LCD_CNT_W'(T_WIN - 1)) begin
						cnt   <= '0;
						state <= ST_READY;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin
					cnt   <= '0;
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// word held for the whole window
	always_ff @(posedge clk) begin
		if (pop)
			word_q <= word;
	end

	always_comb begin
		pins = '0;
		case (state)
			ST_INIT: begin
				if (cnt < LCD_CNT_W'(T_CMD_E)) begin
					pins.e    = 1'b1;
					pins.data = init_cmd;
				end
			end
			ST_PULSE: begin
				pins.rs   = word_q.rs;
				pins.rw   = word_q.rw;  // driven only, nothing sampled back
				pins.data = word_q.data;
				pins.e    = cnt >= LCD_CNT_W'(T_E_RISE) && cnt < LCD_CNT_W'(T_E_FALL);
			end
			default: pins = '0;
		endcase
	end

	a_e_low_when_idle: assert property (
		@(posedge clk) disable iff (!arst_n)
		(state == ST_IDLE || state == ST_READY) |-> !pins.e
	) else $error("enable high outside a command or write");

	// popped word must land on the pins next cycle
	a_pop_to_pins: assert property (
		@(posedge clk) disable iff (!arst_n)
		pop |-> state == ST_READY ##1 (state == ST_PULSE &&
			{pins.rs, pins.rw, pins.data} == $past(word))
	) else $error("pop outside ready or word not presented");

	a_write_e_width: assert property (
		@(posedge clk) disable iff (!arst_n)
		$rose(pins.e) && state == ST_PULSE |-> pins.e [*T_E_HIGH] ##1 !pins.e
	) else $error("write enable pulse has wrong width");

endmodule

// File: source/lcd_pkg.sv
package lcd_pkg;

	// panel time base, scaled down for simulation
	localparam int LCD_TICKS_PER_US = 2;

	// word queue geometry
	localparam int LCD_FIFO_DEPTH = 4;
	localparam int LCD_FIFO_AW    = (LCD_FIFO_DEPTH > 1) ? $clog2(LCD_FIFO_DEPTH) : 1;
	localparam int LCD_LEVEL_W    = LCD_FIFO_AW + 1;

	// HD44780 timing, all in clock ticks
	localparam int T_POWER_UP     = 500 * LCD_TICKS_PER_US;
	localparam int T_CMD_E        = 10 * LCD_TICKS_PER_US;  // e high per init command
	localparam int T_SETTLE_FUNC  = 50 * LCD_TICKS_PER_US;
	localparam int T_SETTLE_DISP  = 50 * LCD_TICKS_PER_US;
	localparam int T_SETTLE_CLEAR = 200 * LCD_TICKS_PER_US;
	localparam int T_SETTLE_ENTRY = 100 * LCD_TICKS_PER_US;
	localparam int T_WIN          = 50 * LCD_TICKS_PER_US;  // one data write
	localparam int T_E_RISE       = 1 * LCD_TICKS_PER_US;
	localparam int T_E_FALL       = 14 * LCD_TICKS_PER_US;
	localparam int T_E_HIGH       = T_E_FALL - T_E_RISE;
	localparam int LCD_CNT_W      = $clog2(T_POWER_UP + 1);

	typedef struct packed {
		logic lines;    // two-line display
		logic font;     // 5x10 dots
		logic disp_on;
		logic cursor_on;
		logic blink;
		logic inc_dec;  // address increments
		logic shift;    // display shifts with writes
	} lcd_cfg_t;

	typedef struct packed {
		logic       rs;
		logic       rw;
		logic [7:0] data;
	} lcd_word_t;

	typedef struct packed {
		logic       e;
		logic       rs;
		logic       rw;
		logic [7:0] data;
	} lcd_pins_t;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [3:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	typedef struct packed {
		logic       init_done;
		logic       busy;
		logic       full;
		logic       empty;
		logic [3:0] level;
	} lcd_status_t;

	typedef enum logic [3:0] {
		REG_CFG    = 4'h0,
		REG_CTRL   = 4'h4,
		REG_TXDATA = 4'h8,
		REG_STATUS = 4'hC
	} lcd_reg_e;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_POWER_UP,
		ST_INIT,
		ST_READY,
		ST_PULSE
	} lcd_state_e;

	typedef enum logic [1:0] {
		STEP_FUNC_SET,
		STEP_DISP_CTRL,
		STEP_CLEAR,
		STEP_ENTRY_MODE
	} lcd_init_step_e;

endpackage

// File: source/lcd_top.sv
`timescale 1ns/1ps

module lcd_top import lcd_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  apb_req_t  apb_req,
	output apb_rsp_t  apb_rsp,
	output lcd_pins_t pins
);

	lcd_cfg_t               cfg;
	lcd_status_t            status;
	lcd_word_t              wdata;
	lcd_word_t              head;
	logic                   init_start;
	logic                   push;
	logic                   pop;
	logic                   full;
	logic                   empty;
	logic [LCD_LEVEL_W-1:0] level;
	logic                   init_done;
	logic                   busy;

	// STATUS readback
	assign status.init_done = init_done;
	assign status.busy      = busy;
	assign status.full      = full;
	assign status.empty     = empty;
	assign status.level     = 4'(level);

	lcd_apb_regs u_regs (
		.clk        (clk),
		.arst_n     (arst_n),
		.apb_req    (apb_req),
		.apb_rsp    (apb_rsp),
		.cfg        (cfg),
		.init_start (init_start),
		.push       (push),
		.wdata      (wdata),
		.status     (status)
	);

	lcd_word_fifo u_fifo (
		.clk    (clk),
		.arst_n (arst_n),
		.push   (push),
		.wdata  (wdata),
		.pop    (pop),
		.rdata  (head),
		.full   (full),
		.empty  (empty),
		.level  (level)
	);

	lcd_ctrl u_ctrl (
		.clk        (clk),
		.arst_n     (arst_n),
		.cfg        (cfg),
		.init_start (init_start),
		.word       (head),
		.empty      (empty),
		.pop        (pop),
		.pins       (pins),
		.init_done  (init_done),
		.busy       (busy)
	);

endmodule

// File: source/lcd_word_fifo.sv
`timescale 1ns/1ps

module lcd_word_fifo import lcd_pkg::*; (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   push,
	input  lcd_word_t              wdata,
	input  logic                   pop,
	output lcd_word_t              rdata,
	output logic                   full,
	output logic                   empty,
	output logic [LCD_LEVEL_W-1:0] level
);

	lcd_word_t              mem [LCD_FIFO_DEPTH];
	logic [LCD_FIFO_AW-1:0] wr_ptr;
	logic [LCD_FIFO_AW-1:0] rd_ptr;
	logic [LCD_LEVEL_W-1:0] count;
	logic                   do_push;
	logic                   do_pop;

	assign full    = count == LCD_LEVEL_W'(LCD_FIFO_DEPTH);
	assign empty   = count == '0;
	assign level   = count;
	assign rdata   = mem[rd_ptr];  // head word, shown ahead of pop
	assign do_push = push && !full;  // dropped when full
	assign do_pop  = pop && !empty;

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == LCD_FIFO_AW'(LCD_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == LCD_FIFO_AW'(LCD_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // both or neither
			endcase
		end
	end

	a_no_pop_empty: assert property (
		@(posedge clk) disable iff (!arst_n)
		pop |-> !empty
	) else $error("pop from empty word queue");

	a_level_bound: assert property (
		@(posedge clk) disable iff (!arst_n)
		level <= LCD_LEVEL_W'(LCD_FIFO_DEPTH)
	) else $error("queue level above depth");

endmodule

// File: tb/lcd_tb_checks.svh
`ifndef LCD_TB_CHECKS_SVH
`define LCD_TB_CHECKS_SVH

task automatic compare_pins(input string name, input lcd_pins_t exp, input lcd_pins_t act);
	if (act !== exp)
		stop_on_error($sformatf("FAILED %s: pins expected %h, actual %h", name, exp, act));
endtask

task automatic compare_status(input string name, input lcd_status_t exp, input lcd_status_t act);
	if (act !== exp)
		stop_on_error($sformatf("FAILED %s: status expected %h, actual %h", name, exp, act));
endtask

task automatic compare_rsp(input string name, input apb_rsp_t exp, input apb_rsp_t act);
	if (act !== exp)
		stop_on_error($sformatf("FAILED %s: apb rsp expected %h, actual %h", name, exp, act));
endtask

task automatic compare_width(input string name, input int exp, input int act);
	if (act != exp)
		stop_on_error($sformatf("FAILED %s: e high cycles expected %0d, actual %0d", name, exp, act));
endtask

// next completed e pulse from the pin monitor
task automatic wait_pulse(input string name, output lcd_pins_t p, output int width);
	int n = 0;
	while (pulse_q.size() == 0) begin
		if (n == PULSE_WAIT)
			stop_on_error($sformatf("timed out waiting for an e pulse in %s", name));
		@(posedge clk);
		n++;
	end
	p     = pulse_q.pop_front();
	width = width_q.pop_front();
endtask

// polls STATUS until init is done and the sequencer is idle
task automatic wait_ready(input string name);
	lcd_status_t st;
	int          polls = 0;
	read_status(name, st);
	while (!(st.init_done && !st.busy)) begin
		if (polls == POLL_LIMIT)
			stop_on_error($sformatf("timed out waiting for the panel to become ready in %s", name));
		polls++;
		read_status(name, st);
	end
endtask

`endif

// File: tb/lcd_tb.sv
`timescale 1ns/1ps

module lcd_tb import lcd_pkg::*; ();

	localparam int E_INIT_CYC  = 10 * LCD_TICKS_PER_US;  // init command e width
	localparam int E_WRITE_CYC = 13 * LCD_TICKS_PER_US;  // 1 us to 14 us in the window
	localparam int PULSE_WAIT  = 3000;
	localparam int POLL_LIMIT  = 3000;
	localparam lcd_cfg_t OVF_CFG = 7'b0011110;

	typedef struct packed {
		lcd_cfg_t   cfg;
		logic [2:0] words;
	} row_t;

	logic      clk = 1'b0;
	logic      arst_n;
	apb_req_t  apb_req;
	apb_rsp_t  apb_rsp;
	lcd_pins_t pins;
	lcd_pins_t pulse_q[$];
	int        width_q[$];
	lcd_word_t sent_q[$];
	lcd_pins_t rise_pins;
	int        high_cnt;
	logic      e_prev = 1'b0;

	// per row the cfg bits (lines font disp cursor blink inc shift) and word count
	row_t rows [3] = '{'{7'b1011010, 3'd3}, '{7'b0110111, 3'd4}, '{7'b1100000, 3'd1}};

	always #2 clk = ~clk;

	lcd_top uut (
		.clk     (clk),
		.arst_n  (arst_n),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.pins    (pins)
	);

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped at first error");
	endtask

	`include "lcd_tb_checks.svh"

	function automatic lcd_status_t status_of(input logic done, input logic busy,
			input logic full, input logic empty, input logic [3:0] level);
		return '{init_done: done, busy: busy, full: full, empty: empty, level: level};
	endfunction

	function automatic apb_rsp_t rsp_of(input logic [31:0] rd, input logic err);
		return '{prdata: rd, pready: 1'b1, pslverr: err};
	endfunction

	// HD44780 init command bytes in issue order
	function automatic logic [7:0] init_byte(input lcd_cfg_t c, input int idx);
		case (idx)
			0: return {4'b0011, c.lines, c.font, 2'b00};
			1: return {5'b00001, c.disp_on, c.cursor_on, c.blink};
			2: return 8'h01;
			default: return {6'b000001, c.inc_dec, c.shift};
		endcase
	endfunction

	// pin monitor sampled mid-cycle
	always @(negedge clk) begin
		if (pins.e && !e_prev) begin
			rise_pins = pins;
			high_cnt  = 1;
		end else if (pins.e) begin
			high_cnt = high_cnt + 1;
			if (pins !== rise_pins)
				stop_on_error("panel pins changed while e was high");
		end else if (e_prev) begin
			pulse_q.push_back(rise_pins);
			width_q.push_back(high_cnt);
		end
		e_prev = pins.e;
	end

	task automatic apb_xfer(input logic write, input logic [3:0] addr, input logic [31:0] data,
			output apb_rsp_t rsp);
		@(posedge clk);
		#1;
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: data};
		@(posedge clk);
		#1;
		apb_req.penable = 1'b1;
		#2;
		rsp = apb_rsp;  // sampled in the access phase before the completing edge
		@(posedge clk);
		#1;
		apb_req = '0;
	endtask

	task automatic write_reg(input string name, input logic [3:0] addr, input logic [31:0] data,
			input logic err);
		apb_rsp_t rsp;
		apb_xfer(1'b1, addr, data, rsp);
		compare_rsp(name, rsp_of(32'd0, err), rsp);
	endtask

	task automatic read_status(input string name, output lcd_status_t st);
		apb_rsp_t rsp;
		apb_rsp_t upper;
		apb_xfer(1'b0, REG_STATUS, 32'd0, rsp);
		upper = rsp;
		upper.prdata[7:0] = 8'd0;  // status byte compared by the caller
		compare_rsp(name, rsp_of(32'd0, 1'b0), upper);
		st = rsp.prdata[7:0];
	endtask

	task automatic send_word(input string name);
		logic [9:0] r;
		lcd_word_t  w;
		r = 10'($urandom);
		w = r;
		write_reg(name, REG_TXDATA, {22'd0, r}, 1'b0);
		sent_q.push_back(w);
	endtask

	task automatic check_init(input string name, input lcd_cfg_t c);
		lcd_pins_t p;
		int        w;
		for (int i = 0; i < 4; i++) begin
			wait_pulse(name, p, w);
			compare_pins(name, '{e: 1'b1, rs: 1'b0, rw: 1'b0, data: init_byte(c, i)}, p);
			compare_width(name, E_INIT_CYC, w);
		end
	endtask

	task automatic check_words(input string name, input int n);
		lcd_pins_t p;
		lcd_word_t exp;
		int        w;
		for (int i = 0; i < n; i++) begin
			exp = sent_q.pop_front();
			wait_pulse(name, p, w);
			compare_pins(name, '{e: 1'b1, rs: exp.rs, rw: exp.rw, data: exp.data}, p);
			compare_width(name, E_WRITE_CYC, w);
		end
	endtask

	initial begin
		apb_rsp_t    rsp;
		lcd_status_t st;
		string       row_name;
		int          early;
		apb_req = '0;
		arst_n  = 1'b0;
		void'($urandom(32'hb5e4_ace3));
		repeat (5) @(posedge clk);
		#1;
		arst_n = 1'b1;

		compare_pins("reset_pins", '0, pins);
		read_status("reset_status", st);
		compare_status("reset_status", status_of(1'b0, 1'b0, 1'b0, 1'b1, 4'd0), st);
		apb_xfer(1'b0, REG_CFG, 32'd0, rsp);
		compare_rsp("reset_cfg", rsp_of(32'd0, 1'b0), rsp);

		apb_xfer(1'b0, 4'h2, 32'd0, rsp);
		compare_rsp("unmapped_read", rsp_of(32'd0, 1'b1), rsp);
		write_reg("unmapped_write", 4'h6, 32'd1, 1'b1);
		write_reg("status_write", REG_STATUS, 32'hff, 1'b1);
		apb_xfer(1'b0, REG_STATUS, 32'd0, rsp);
		compare_rsp("status_read", rsp_of({24'd0, status_of(1'b0, 1'b0, 1'b0, 1'b1, 4'd0)},
			1'b0), rsp);

		foreach (rows[i]) begin
			row_name = $sformatf("row%0d", i);
			write_reg(row_name, REG_CFG, 32'(rows[i].cfg), 1'b0);
			apb_xfer(1'b0, REG_CFG, 32'd0, rsp);
			compare_rsp(row_name, rsp_of(32'(rows[i].cfg), 1'b0), rsp);
			write_reg(row_name, REG_CTRL, 32'd1, 1'b0);
			early = (rows[i].words > 3'd2) ? 2 : int'(rows[i].words);  // queued during power-up
			for (int k = 0; k < early; k++)
				send_word(row_name);
			check_init(row_name, rows[i].cfg);
			for (int k = early; k < int'(rows[i].words); k++)
				send_word(row_name);
			check_words(row_name, int'(rows[i].words));
			wait_ready(row_name);
			read_status(row_name, st);
			compare_status(row_name, status_of(1'b1, 1'b0, 1'b0, 1'b1, 4'd0), st);
		end

		// overfill the queue while the panel powers up
		write_reg("overflow", REG_CFG, 32'(OVF_CFG), 1'b0);
		write_reg("overflow", REG_CTRL, 32'd1, 1'b0);
		for (int k = 0; k < LCD_FIFO_DEPTH; k++)
			send_word("overflow");
		write_reg("overflow_extra", REG_TXDATA, 32'h2a5, 1'b1);
		read_status("overflow_status", st);
		compare_status("overflow_status", status_of(1'b0, 1'b1, 1'b1, 1'b0, 4'd4), st);
		check_init("overflow", OVF_CFG);
		check_words("overflow", LCD_FIFO_DEPTH);
		wait_ready("overflow");
		read_status("overflow_drained", st);
		compare_status("overflow_drained", status_of(1'b1, 1'b0, 1'b0, 1'b1, 4'd0), st);
		if (pulse_q.size() != 0)
			stop_on_error("an extra e pulse appeared after the queued words");

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule
